/* Bender.yml */
package:
  name: register_access_stall

sources:
  - logic/stall_pkg.sv
  - logic/operand_decode.sv
  - logic/scoreboard_table.sv
  - logic/stall_check.sv
  - logic/register_access_stall.sv
  - target: test
    files:
      - test/stall_checker.sv
      - test/tb_register_access_stall.sv

/* logic/operand_decode.sv */
// Operand register decode
module operand_decode (
    input  stall_pkg::reg_size_e   register_size,
    input  stall_pkg::operand_t    op0,
    input  stall_pkg::operand_t    op1,
    input  stall_pkg::modrm_t      mod_rm,
    input  stall_pkg::sib_t        sib,
    output stall_pkg::src_set_t    sources,
    output stall_pkg::reg_access_t dest
);

    // registers named by the mod r/m and sib bytes, shared by both operands
    stall_pkg::reg_access_t modrm_r0;
    stall_pkg::reg_access_t modrm_r1;

    // first source of one operand
    function automatic stall_pkg::reg_access_t operand_r0(
        input stall_pkg::operand_t    op,
        input stall_pkg::reg_size_e   size,
        input stall_pkg::reg_access_t from_modrm
    );
        stall_pkg::reg_access_t r0;
        r0.idx   = op.reg_num;
        r0.valid = 1'b0;
        case (op.op_type)
            // plain register or register-indirect memory
            stall_pkg::OP_REGISTER,
            stall_pkg::OP_MEMORY: begin
                r0.idx   = stall_pkg::sized_reg_index(op.reg_num, size);
                r0.valid = 1'b1;
            end
            stall_pkg::OP_MODRM: begin
                r0 = from_modrm;
            end
            // segment, mm, immediate and none read no general register
            default: begin
                r0.valid = 1'b0;
            end
        endcase
        return r0;
    endfunction

    // second source, only the sib index can supply it
    function automatic stall_pkg::reg_access_t operand_r1(
        input stall_pkg::operand_t    op,
        input stall_pkg::reg_access_t from_modrm
    );
        stall_pkg::reg_access_t r1;
        r1 = from_modrm;
        if (op.op_type != stall_pkg::OP_MODRM) begin
            r1.valid = 1'b0;
        end
        return r1;
    endfunction

    always_comb begin
        // mode 00 with rm 101 is disp32 only, no base register
        modrm_r0.valid = !(mod_rm.mode == 2'b00 && mod_rm.rm == 3'b101);
        if (mod_rm.mode == 2'b11) begin
            // register form, byte size aliasing applies
            modrm_r0.idx = stall_pkg::sized_reg_index(mod_rm.rm, register_size);
        end else if (mod_rm.rm != 3'b100) begin
            // memory through a 32-bit base, never aliased
            modrm_r0.idx = mod_rm.rm;
        end else begin
            // rm 100 escapes to the sib byte
            modrm_r0.idx = sib.base;
        end

        // index 100 means no index register
        modrm_r1.valid = mod_rm.mode != 2'b11 && mod_rm.rm == 3'b100 && sib.index != 3'b100;
        modrm_r1.idx   = sib.index;
    end

    always_comb begin
        sources.op0_r0 = operand_r0(op0, register_size, modrm_r0);
        sources.op0_r1 = operand_r1(op0, modrm_r1);
        sources.op1_r0 = operand_r0(op1, register_size, modrm_r0);
        sources.op1_r1 = operand_r1(op1, modrm_r1);
    end

    // op0 writes a register for a plain register or mod r/m register form
    always_comb begin
        dest.valid = 1'b0;
        dest.idx   = stall_pkg::sized_reg_index(op0.reg_num, register_size);
        if (op0.op_type == stall_pkg::OP_REGISTER) begin
            dest.valid = 1'b1;
        end else if (op0.op_type == stall_pkg::OP_MODRM && mod_rm.mode == 2'b11) begin
            dest.valid = 1'b1;
            dest.idx   = stall_pkg::sized_reg_index(mod_rm.rm, register_size);
        end
    end

    // an index register always comes with a base through the sib byte
    always_comb begin
        assert final (!sources.op0_r1.valid || sources.op0_r0.valid)
            else $error("op0 index source without base source");
        assert final (!sources.op1_r1.valid || sources.op1_r0.valid)
            else $error("op1 index source without base source");
    end

endmodule

/* logic/register_access_stall.sv */
// Register access stall unit
module register_access_stall #(
    parameter int unsigned COUNT_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  stall_pkg::reg_size_e  register_size,
    input  stall_pkg::operand_t   op0,
    input  stall_pkg::operand_t   op1,
    input  stall_pkg::modrm_t     mod_rm,
    input  stall_pkg::sib_t       sib,
    input  logic                  stack_op,
    input  stall_pkg::writeback_t wb,
    input  logic                  next_stage_ready,
    output logic                  is_stall
);

    // registers read and written by the instruction in decode
    stall_pkg::src_set_t    sources;
    stall_pkg::reg_access_t dest;

    // in-flight write count per register
    logic [stall_pkg::NUM_REGS-1:0][COUNT_WIDTH-1:0] counts;

    operand_decode operand_decode_inst (
        .register_size (register_size),
        .op0           (op0),
        .op1           (op1),
        .mod_rm        (mod_rm),
        .sib           (sib),
        .sources       (sources),
        .dest          (dest)
    );

    // the table does not look at is_stall, the stage drops ready instead
    scoreboard_table #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) scoreboard_table_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .dest             (dest),
        .next_stage_ready (next_stage_ready),
        .wb               (wb),
        .counts           (counts)
    );

    stall_check #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) stall_check_inst (
        .sources  (sources),
        .counts   (counts),
        .stack_op (stack_op),
        .is_stall (is_stall)
    );

endmodule

/* logic/scoreboard_table.sv */
// In-flight write scoreboard
module scoreboard_table #(
    parameter int unsigned COUNT_WIDTH = 4
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  stall_pkg::reg_access_t                              dest,
    input  logic                                                next_stage_ready,
    input  stall_pkg::writeback_t                               wb,
    output logic [stall_pkg::NUM_REGS-1:0][COUNT_WIDTH-1:0]     counts
);

    // writeback index after byte aliasing
    stall_pkg::reg_idx_t wb_idx;

    // per register reserve and release strobes
    logic [stall_pkg::NUM_REGS-1:0] inc;
    logic [stall_pkg::NUM_REGS-1:0] dec;

    assign wb_idx = stall_pkg::sized_reg_index(wb.reg_num, wb.size);

    always_comb begin
        for (int i = 0; i < stall_pkg::NUM_REGS; i++) begin
            // reserve only once the instruction actually moves on
            inc[i] = dest.valid && next_stage_ready && dest.idx == stall_pkg::reg_idx_t'(i);
            // release does not wait on the pipeline
            dec[i] = wb.enable && wb_idx == stall_pkg::reg_idx_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < stall_pkg::NUM_REGS; i++) begin
                // reserve and release on the same entry cancel out
                if (inc[i] && !dec[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end else if (dec[i] && !inc[i]) begin
                    counts[i] <= counts[i] - 1'b1;
                end
            end
        end
    end

    // wrap in either direction would lose track of outstanding writes
    for (genvar g = 0; g < stall_pkg::NUM_REGS; g++) begin : g_count_check
        assert property (@(posedge clk) disable iff (!rst_n)
            (inc[g] && !dec[g]) |-> counts[g] != {COUNT_WIDTH{1'b1}})
            else $error("scoreboard entry %0d overflows", g);

        assert property (@(posedge clk) disable iff (!rst_n)
            (dec[g] && !inc[g]) |-> counts[g] != '0)
            else $error("writeback to entry %0d with no write in flight", g);
    end

endmodule

/* logic/stall_check.sv */
// Source hazard check
module stall_check #(
    parameter int unsigned COUNT_WIDTH = 4
) (
    input  stall_pkg::src_set_t                                 sources,
    input  logic [stall_pkg::NUM_REGS-1:0][COUNT_WIDTH-1:0]     counts,
    input  logic                                                stack_op,
    output logic                                                is_stall
);

    // the four sources as one indexable list
    stall_pkg::reg_access_t [3:0] src_list;

    // per source hit on a busy register
    logic [3:0] src_busy;
    logic       stack_busy;

    assign src_list = {sources.op0_r0, sources.op0_r1, sources.op1_r0, sources.op1_r1};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_busy[i] = src_list[i].valid && counts[src_list[i].idx] != '0;
        end
    end

    // push, pop, call and ret need esp settled even with no explicit source
    assign stack_busy = stack_op && counts[stall_pkg::STACK_REG] != '0;

    assign is_stall = |src_busy || stack_busy;

    // counts are all known once reset has cleared the table
    always_comb begin
        if (!$isunknown(counts)) begin
            assert final (!$isunknown(is_stall))
                else $error("is_stall unknown after reset");
        end
    end

endmodule

/* logic/stall_pkg.sv */
// Register stall shared definitions
package stall_pkg;

    // general register file of the decode stage
    localparam int unsigned NUM_REGS = 8;

    // esp lives at index 4, push and pop depend on it
    localparam int unsigned STACK_REG = 4;

    typedef logic [2:0] reg_idx_t;

    // operand kinds as produced by the instruction decoder
    typedef enum logic [2:0] {
        OP_NONE      = 3'd0,
        OP_REGISTER  = 3'd1,
        OP_SEGMENT   = 3'd2,
        OP_MM        = 3'd3,
        OP_MODRM     = 3'd4,
        OP_IMMEDIATE = 3'd5,
        OP_MEMORY    = 3'd6
    } op_type_e;

    // operand width, value 3 is never driven
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } reg_size_e;

    // one decoded operand with its register field
    typedef struct packed {
        op_type_e op_type;
        reg_idx_t reg_num;
    } operand_t;

    // mod r/m byte, mode in the top two bits
    typedef struct packed {
        logic [1:0] mode;
        reg_idx_t   reg_op;
        reg_idx_t   rm;
    } modrm_t;

    // sib byte, scale in the top two bits
    typedef struct packed {
        logic [1:0] scale;
        reg_idx_t   index;
        reg_idx_t   base;
    } sib_t;

    // register reference with a qualifier
    typedef struct packed {
        reg_idx_t idx;
        logic     valid;
    } reg_access_t;

    // up to two registers per operand
    typedef struct packed {
        reg_access_t op0_r0;
        reg_access_t op0_r1;
        reg_access_t op1_r0;
        reg_access_t op1_r1;
    } src_set_t;

    // completed register write from the writeback stage
    typedef struct packed {
        reg_idx_t  reg_num;
        reg_size_e size;
        logic      enable;
    } writeback_t;

    // byte registers ah, ch, dh, bh (4 to 7) sit inside eax..ebx
    function automatic reg_idx_t sized_reg_index(input reg_idx_t idx, input reg_size_e size);
        reg_idx_t sized;
        sized = idx;
        if (size == SIZE_BYTE && idx[2]) begin
            sized = {1'b0, idx[1:0]};
        end
        return sized;
    endfunction

endpackage

/* test/stall_checker.sv */
// Stall reference model and checker
module stall_checker #(
    parameter int unsigned COUNT_WIDTH = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  stall_pkg::reg_size_e             register_size,
    input  stall_pkg::operand_t              op0,
    input  stall_pkg::operand_t              op1,
    input  stall_pkg::modrm_t                mod_rm,
    input  stall_pkg::sib_t                  sib,
    input  logic                             stack_op,
    input  stall_pkg::writeback_t            wb,
    input  logic                             next_stage_ready,
    input  logic                             is_stall,
    output logic                             expect_stall,
    output logic [stall_pkg::NUM_REGS-1:0]   busy_regs,
    output logic                             near_full,
    output int                               error_count,
    output int                               check_count
);

    // outstanding writes per register, unbounded
    int model_count [stall_pkg::NUM_REGS];

    // byte regs 4 to 7 are the high halves of 0 to 3
    function automatic int alias_reg(input logic [2:0] idx, input stall_pkg::reg_size_e sz);
        if (sz == stall_pkg::SIZE_BYTE && idx >= 3'd4) begin
            return int'(idx) - 4;
        end
        return int'(idx);
    endfunction

    // true when one operand reads a register with a write in flight
    function automatic logic operand_busy(
        input stall_pkg::operand_t   op,
        input stall_pkg::reg_size_e  sz,
        input stall_pkg::modrm_t     m,
        input stall_pkg::sib_t       s,
        input int                    cnt [stall_pkg::NUM_REGS]
    );
        logic busy;
        busy = 1'b0;
        if (op.op_type == stall_pkg::OP_REGISTER || op.op_type == stall_pkg::OP_MEMORY) begin
            busy = cnt[alias_reg(op.reg_num, sz)] != 0;
        end else if (op.op_type == stall_pkg::OP_MODRM) begin
            if (m.mode == 2'b11) begin
                busy = cnt[alias_reg(m.rm, sz)] != 0;
            end else if (m.rm == 3'b100) begin
                // sib form, index 100 means no index
                busy = cnt[s.base] != 0 || (s.index != 3'b100 && cnt[s.index] != 0);
            end else if (!(m.mode == 2'b00 && m.rm == 3'b101)) begin
                busy = cnt[m.rm] != 0;
            end
        end
        return busy;
    endfunction

    // expected is_stall from the decode inputs and the model counts
    function automatic logic predict_stall(input int cnt [stall_pkg::NUM_REGS]);
        logic stall;
        stall = operand_busy(op0, register_size, mod_rm, sib, cnt);
        stall = stall || operand_busy(op1, register_size, mod_rm, sib, cnt);
        // esp busy blocks push and pop
        stall = stall || (stack_op && cnt[4] != 0);
        return stall;
    endfunction

    always @(posedge clk) begin : model_update
        int dest;
        int rel;
        dest = -1;
        rel  = -1;
        if (!rst_n) begin
            for (int i = 0; i < stall_pkg::NUM_REGS; i++) begin
                model_count[i] <= 0;
            end
        end else begin
            // only a register destination of op0 reserves
            if (next_stage_ready && op0.op_type == stall_pkg::OP_REGISTER) begin
                dest = alias_reg(op0.reg_num, register_size);
            end else if (next_stage_ready && op0.op_type == stall_pkg::OP_MODRM
                         && mod_rm.mode == 2'b11) begin
                dest = alias_reg(mod_rm.rm, register_size);
            end
            if (wb.enable) begin
                rel = alias_reg(wb.reg_num, wb.size);
            end
            // same register both ways leaves it alone
            if (dest != rel) begin
                if (dest >= 0) begin
                    model_count[dest] <= model_count[dest] + 1;
                end
                if (rel >= 0) begin
                    model_count[rel] <= model_count[rel] - 1;
                end
            end
        end
    end

    always_comb begin
        near_full = 1'b0;
        for (int i = 0; i < stall_pkg::NUM_REGS; i++) begin
            busy_regs[i] = model_count[i] != 0;
            // one more reservation must still fit the counter
            if (model_count[i] >= (1 << COUNT_WIDTH) - 2) begin
                near_full = 1'b1;
            end
        end
        expect_stall = predict_stall(model_count);
    end

    // inputs and counts are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_count = check_count + 1;
            if (is_stall !== expect_stall) begin
                error_count = error_count + 1;
                $display("ERR %0t is_stall got %b expected %b", $time, is_stall, expect_stall);
            end
        end
    end

endmodule

/* test/tb_register_access_stall.sv */
// Register access stall testbench
module tb_register_access_stall;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 3;
    localparam int SWEEP_CYCLES    = 256;
    // upper bound for all directed sequences
    localparam int DIRECTED_CYCLES = 64;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + SWEEP_CYCLES + DIRECTED_CYCLES
                                     + RANDOM_CYCLES + 4;

    logic                           clk;
    logic                           rst_n;
    stall_pkg::reg_size_e           register_size;
    stall_pkg::operand_t            op0;
    stall_pkg::operand_t            op1;
    stall_pkg::modrm_t              mod_rm;
    stall_pkg::sib_t                sib;
    logic                           stack_op;
    stall_pkg::writeback_t          wb;
    logic                           next_stage_ready;
    logic                           is_stall;

    // model view from the checker
    logic                           expect_stall;
    logic [stall_pkg::NUM_REGS-1:0] busy_regs;
    logic                           near_full;
    int                             error_count;
    int                             check_count;

    register_access_stall #(.COUNT_WIDTH(4)) register_access_stall_inst (
        .clk(clk), .rst_n(rst_n), .register_size(register_size), .op0(op0), .op1(op1),
        .mod_rm(mod_rm), .sib(sib), .stack_op(stack_op), .wb(wb),
        .next_stage_ready(next_stage_ready), .is_stall(is_stall)
    );

    stall_checker #(.COUNT_WIDTH(4)) stall_checker_inst (
        .clk(clk), .rst_n(rst_n), .register_size(register_size), .op0(op0), .op1(op1),
        .mod_rm(mod_rm), .sib(sib), .stack_op(stack_op), .wb(wb),
        .next_stage_ready(next_stage_ready), .is_stall(is_stall),
        .expect_stall(expect_stall), .busy_regs(busy_regs), .near_full(near_full),
        .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // no instruction, no writeback, stage not moving
    task automatic clear_inputs();
        op0              = '{op_type: stall_pkg::OP_NONE, reg_num: 3'd0};
        op1              = '{op_type: stall_pkg::OP_NONE, reg_num: 3'd0};
        mod_rm           = '0;
        sib              = '0;
        register_size    = stall_pkg::SIZE_DWORD;
        stack_op         = 1'b0;
        wb               = '0;
        next_stage_ready = 1'b0;
    endtask

    // move to the drive point of the next cycle
    task automatic step();
        @(posedge clk);
        #2;
        clear_inputs();
    endtask

    task automatic reserve(input logic [2:0] idx, input stall_pkg::reg_size_e sz);
        step();
        op0              = '{op_type: stall_pkg::OP_REGISTER, reg_num: idx};
        register_size    = sz;
        next_stage_ready = 1'b1;
    endtask

    // adds a writeback to the cycle already being driven
    task automatic add_writeback(input logic [2:0] idx, input stall_pkg::reg_size_e sz);
        wb = '{reg_num: idx, size: sz, enable: 1'b1};
    endtask

    task automatic release_write(input logic [2:0] idx, input stall_pkg::reg_size_e sz);
        step();
        add_writeback(idx, sz);
    endtask

    task automatic read_reg(input logic [2:0] idx, input stall_pkg::reg_size_e sz);
        step();
        op1           = '{op_type: stall_pkg::OP_REGISTER, reg_num: idx};
        register_size = sz;
    endtask

    task automatic read_sib(input logic [1:0] mode, input logic [2:0] rm,
                            input logic [2:0] base, input logic [2:0] index);
        step();
        op1    = '{op_type: stall_pkg::OP_MODRM, reg_num: 3'd0};
        mod_rm = '{mode: mode, reg_op: 3'd0, rm: rm};
        sib    = '{scale: 2'd0, index: index, base: base};
    endtask

    // many source shapes with an empty table, ready low
    task automatic after_reset_sweep();
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            step();
            op0           = '{op_type: stall_pkg::OP_MODRM, reg_num: 3'(i)};
            op1           = '{op_type: stall_pkg::op_type_e'(i % 7), reg_num: 3'(i >> 3)};
            mod_rm        = stall_pkg::modrm_t'(8'(i));
            sib           = stall_pkg::sib_t'(8'(i * 37));
            register_size = stall_pkg::reg_size_e'(i % 3);
        end
    endtask

    task automatic directed_sequences();
        reserve(3'd3, stall_pkg::SIZE_DWORD);
        repeat (3) read_reg(3'd3, stall_pkg::SIZE_DWORD);
        // still stalled while the release is in flight
        read_reg(3'd3, stall_pkg::SIZE_DWORD);
        add_writeback(3'd3, stall_pkg::SIZE_DWORD);
        read_reg(3'd3, stall_pkg::SIZE_DWORD);
        // ready low, nothing reserved
        step();
        op0 = '{op_type: stall_pkg::OP_REGISTER, reg_num: 3'd5};
        read_reg(3'd5, stall_pkg::SIZE_DWORD);

        // sib base, sib index, index 100 and disp32 only
        reserve(3'd1, stall_pkg::SIZE_DWORD);
        reserve(3'd6, stall_pkg::SIZE_DWORD);
        reserve(3'd4, stall_pkg::SIZE_DWORD);
        reserve(3'd5, stall_pkg::SIZE_DWORD);
        read_sib(2'b01, 3'b100, 3'd1, 3'd2);
        read_sib(2'b00, 3'b100, 3'd0, 3'd6);
        read_sib(2'b10, 3'b100, 3'd0, 3'b100);
        read_sib(2'b00, 3'b101, 3'd0, 3'd0);
        read_sib(2'b10, 3'b101, 3'd0, 3'd0);
        release_write(3'd1, stall_pkg::SIZE_DWORD);
        release_write(3'd6, stall_pkg::SIZE_WORD);
        release_write(3'd4, stall_pkg::SIZE_DWORD);
        release_write(3'd5, stall_pkg::SIZE_DWORD);

        // dh is part of edx
        reserve(3'd6, stall_pkg::SIZE_BYTE);
        read_reg(3'd2, stall_pkg::SIZE_DWORD);
        read_reg(3'd6, stall_pkg::SIZE_DWORD);
        release_write(3'd6, stall_pkg::SIZE_BYTE);
        read_reg(3'd2, stall_pkg::SIZE_DWORD);

        reserve(3'd4, stall_pkg::SIZE_DWORD);
        repeat (2) begin
            step();
            stack_op = 1'b1;
        end
        release_write(3'd4, stall_pkg::SIZE_DWORD);
        step();
        stack_op = 1'b1;

        // two writes in flight need two writebacks
        reserve(3'd7, stall_pkg::SIZE_DWORD);
        reserve(3'd7, stall_pkg::SIZE_DWORD);
        release_write(3'd7, stall_pkg::SIZE_DWORD);
        read_reg(3'd7, stall_pkg::SIZE_DWORD);
        release_write(3'd7, stall_pkg::SIZE_DWORD);
        read_reg(3'd7, stall_pkg::SIZE_DWORD);
        reserve(3'd0, stall_pkg::SIZE_DWORD);
        reserve(3'd0, stall_pkg::SIZE_DWORD);
        add_writeback(3'd0, stall_pkg::SIZE_DWORD);
        read_reg(3'd0, stall_pkg::SIZE_DWORD);
        release_write(3'd0, stall_pkg::SIZE_DWORD);
        read_reg(3'd0, stall_pkg::SIZE_DWORD);
    endtask

    task automatic random_traffic();
        int r;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            step();
            op0.op_type   = stall_pkg::op_type_e'($urandom % 7);
            op0.reg_num   = 3'($urandom);
            op1.op_type   = stall_pkg::op_type_e'($urandom % 7);
            op1.reg_num   = 3'($urandom);
            mod_rm        = stall_pkg::modrm_t'(8'($urandom));
            sib           = stall_pkg::sib_t'(8'($urandom));
            register_size = stall_pkg::reg_size_e'($urandom % 3);
            stack_op      = $urandom % 4 == 0;
            // release only what the model says is outstanding
            if (busy_regs != '0 && $urandom % 2 == 0) begin
                r = $urandom % 8;
                while (!busy_regs[r]) begin
                    r = (r + 1) % 8;
                end
                wb.enable = 1'b1;
                wb.reg_num = 3'(r);
                if (r < 4) begin
                    wb.size = stall_pkg::reg_size_e'($urandom % 3);
                    if (wb.size == stall_pkg::SIZE_BYTE && $urandom % 2 == 0) begin
                        wb.reg_num = 3'(r + 4);
                    end
                end else begin
                    wb.size = ($urandom % 2 == 0) ? stall_pkg::SIZE_WORD : stall_pkg::SIZE_DWORD;
                end
            end
            // the stage holds while stalled or near counter overflow
            #1;
            next_stage_ready = !expect_stall && !near_full && ($urandom % 4 != 0);
        end
    endtask

    initial begin
        void'($urandom(32'h877));
        rst_n = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        after_reset_sweep();
        directed_sequences();
        random_traffic();
        step();
        @(negedge clk);
        #1;
        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("%0d errors in %0d checks", error_count, check_count);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* verilog.f */
logic/stall_pkg.sv
logic/operand_decode.sv
logic/scoreboard_table.sv
logic/stall_check.sv
logic/register_access_stall.sv
test/stall_checker.sv
test/tb_register_access_stall.sv
